// ==== Makefile ====
# Verilator build of the hash lookup testbench, one binary per insert mode

VERILATOR ?= verilator
TOP       ?= tb_htable_multi
FILELIST  ?= htable_multi_top.f
BUILD_DIR ?= build
MODES     ?= rr bc
VFLAGS    ?= --binary --timing -j 0

# Testbench parameter value for each mode
MODE_SEL_rr := 0
MODE_SEL_bc := 1

SRCS := $(filter %.sv %.v,$(shell cat $(FILELIST)))
HDRS := htable_consts.svh
BINS := $(foreach m,$(MODES),$(BUILD_DIR)/$(m)/V$(TOP))

.PHONY: all run clean

all: $(BINS)

$(BUILD_DIR)/%/V$(TOP): $(SRCS) $(HDRS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) \
	    -GMODE_SEL=$(MODE_SEL_$*) -Mdir $(BUILD_DIR)/$* -o V$(TOP)

run: $(BINS)
	@status=0; \
	for m in $(MODES); do \
	    $(BUILD_DIR)/$$m/V$(TOP) > $(BUILD_DIR)/$$m/sim.log 2>&1; \
	    cat $(BUILD_DIR)/$$m/sim.log; \
	    if grep -q '^\*\* PASS \*\*$$' $(BUILD_DIR)/$$m/sim.log; then \
	        echo "mode $$m passed"; \
	    else \
	        echo "mode $$m failed, see $(BUILD_DIR)/$$m/sim.log"; \
	        status=1; \
	    fi; \
	done; \
	exit $$status

clean:
	rm -rf $(BUILD_DIR)

// ==== htable_consts.svh ====
`ifndef HTABLE_CONSTS_SVH
`define HTABLE_CONSTS_SVH

// ------------------------------
// Data widths
// ------------------------------

// Key and value widths
`define HTABLE_KEY_W 16
`define HTABLE_VALUE_W 16

// ------------------------------
// Table geometry
// ------------------------------

// Tables searched in parallel
`define HTABLE_NUM_TABLES 3

// Index width, 64 entries per table
`define HTABLE_ADDR_W 6

// ------------------------------
// Flow control
// ------------------------------

// Lookup credits after reset, also the response FIFO depth
`define HTABLE_LOOKUP_CREDITS 4

`endif

// ==== htable_hash.sv ====
`timescale 1ns/10ps
`include "htable_consts.svh"

module htable_hash (
    input  logic                  clk,
    input  logic                  srst,
    input  htable_pkg::key_t      key,
    input  logic                  key_valid,
    output htable_pkg::tbl_addr_t idx [`HTABLE_NUM_TABLES],
    output logic                  idx_valid
);
    import htable_pkg::*;

    localparam int NUM_TABLES = `HTABLE_NUM_TABLES;
    localparam int KEY_W      = `HTABLE_KEY_W;
    localparam int HALF_W     = KEY_W / 2;

    // Rotate left by 5 bits per table, fold the two bytes, keep the low bits
    function automatic tbl_addr_t hash_idx(input key_t k, input int tbl);
        int                sh;
        key_t              rot;
        logic [HALF_W-1:0] fold;
        sh   = (5 * tbl) % KEY_W;
        rot  = (k << sh) | (k >> ((KEY_W - sh) % KEY_W));
        fold = rot[KEY_W-1:HALF_W] ^ rot[HALF_W-1:0];
        return fold[`HTABLE_ADDR_W-1:0];
    endfunction

    always_ff @(posedge clk) begin
        if (srst) begin
            idx_valid <= 1'b0;
        end else begin
            idx_valid <= key_valid;
        end
    end

    always_ff @(posedge clk) begin
        for (int t = 0; t < NUM_TABLES; t++) begin
            idx[t] <= hash_idx(key, t);
        end
    end

endmodule : htable_hash

// ==== htable_mem.sv ====
`timescale 1ns/10ps
`include "htable_consts.svh"

module htable_mem #(
    parameter int ADDR_W = `HTABLE_ADDR_W
) (
    input  logic                   clk,

    // Write port, shared by inserts and the wipe
    input  logic                   wr_en,
    input  htable_pkg::tbl_addr_t  wr_addr,
    input  htable_pkg::tbl_entry_t wr_entry,

    // Read-and-compare port
    input  logic                   rd_en,
    input  htable_pkg::tbl_addr_t  rd_addr,
    input  htable_pkg::key_t       rd_key,
    output logic                   rd_done,
    output logic                   rd_hit,
    output htable_pkg::value_t     rd_value
);
    import htable_pkg::*;

    localparam int DEPTH = 1 << ADDR_W;

    tbl_entry_t entries [DEPTH];
    tbl_entry_t rd_entry_q;
    key_t       rd_key_q;

    // ------------------------------
    // Storage
    // ------------------------------

    always_ff @(posedge clk) begin
        if (wr_en) begin
            entries[wr_addr] <= wr_entry;
        end
    end

    // ------------------------------
    // Registered read
    // ------------------------------

    // Key is captured with the entry so the compare lines up
    always_ff @(posedge clk) begin
        rd_done <= rd_en;
        if (rd_en) begin
            rd_entry_q <= entries[rd_addr];
            rd_key_q   <= rd_key;
        end
    end

    // Compare
    assign rd_hit   = rd_entry_q.valid && (rd_entry_q.key == rd_key_q);
    assign rd_value = rd_hit ? rd_entry_q.value : '0;

endmodule : htable_mem

// ==== htable_multi_ctrl.sv ====
`timescale 1ns/10ps
`include "htable_consts.svh"

module htable_multi_ctrl #(
    parameter htable_pkg::htable_insert_mode_t INSERT_MODE = htable_pkg::INSERT_ROUND_ROBIN
) (
    input  logic                                clk,
    input  logic                                srst,
    input  logic                                clear,
    output logic                                init_done,

    // Application requests
    input  logic                                lookup_valid,
    input  htable_pkg::lookup_req_t             lookup_req,
    input  logic                                insert_valid,
    input  htable_pkg::insert_req_t             insert_req,

    // Shared hash unit
    output htable_pkg::key_t                    hash_key,
    output logic                                hash_key_valid,
    input  htable_pkg::tbl_addr_t               idx [`HTABLE_NUM_TABLES],
    input  logic                                idx_valid,

    // Table read and write
    output logic                                key_valid_lookup,
    output htable_pkg::key_t                    tbl_rd_key,
    output logic [`HTABLE_NUM_TABLES-1:0]       tbl_wr_en,
    output htable_pkg::tbl_addr_t               tbl_wr_addr [`HTABLE_NUM_TABLES],
    output htable_pkg::tbl_entry_t              tbl_wr_entry,

    // Response FIFOs
    output logic                                fifo_srst,
    input  logic [`HTABLE_NUM_TABLES-1:0]       fifo_empty,
    output logic                                fifo_pop,
    input  htable_pkg::lookup_resp_t            fifo_data [`HTABLE_NUM_TABLES],

    // Response and credits
    output logic                                resp_valid,
    output htable_pkg::lookup_resp_t            resp,
    output logic                                lookup_credit,
    output logic                                insert_credit
);
    import htable_pkg::*;

    localparam int NUM_TABLES = `HTABLE_NUM_TABLES;

    htable_ctrl_state_t      state;
    tbl_addr_t               wipe_addr;
    tbl_sel_t                rr_sel;
    logic                    ins_flag_q;
    key_t                    key_q;
    value_t                  value_q;
    logic                    ins_wr;
    logic                    ins_wr_q;
    logic [NUM_TABLES-1:0]   ins_mask;
    lookup_resp_t            resp_next;

    // ------------------------------
    // Wipe and run FSM
    // ------------------------------

    always_ff @(posedge clk) begin
        if (srst || clear) begin
            state     <= ST_WIPE;
            wipe_addr <= '0;
        end else if (state == ST_WIPE) begin
            wipe_addr <= wipe_addr + 1'b1;
            if (&wipe_addr) begin
                state <= ST_RUN;
            end
        end
    end

    assign init_done = (state == ST_RUN);

    always_ff @(posedge clk) begin
        fifo_srst <= srst || clear;
    end

    // ------------------------------
    // Hash input and insert tagging
    // ------------------------------

    // Inserts and lookups never arrive together
    assign hash_key       = insert_valid ? insert_req.key : lookup_req.key;
    assign hash_key_valid = (state == ST_RUN) && (lookup_valid || insert_valid);

    always_ff @(posedge clk) begin
        if (srst) begin
            ins_flag_q <= 1'b0;
        end else begin
            ins_flag_q <= (state == ST_RUN) && insert_valid;
        end
    end

    // Key and value delayed to meet the hashed index
    always_ff @(posedge clk) begin
        key_q   <= hash_key;
        value_q <= insert_req.value;
    end

    assign key_valid_lookup = idx_valid && !ins_flag_q;
    assign tbl_rd_key       = key_q;
    assign ins_wr           = idx_valid && ins_flag_q;

    // ------------------------------
    // Insert distribution
    // ------------------------------

    always_comb begin
        ins_mask = '0;
        if (INSERT_MODE == INSERT_BROADCAST) begin
            ins_mask = '1;
        end else begin
            ins_mask[rr_sel] = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (srst || clear) begin
            rr_sel <= '0;
        end else if (ins_wr) begin
            if (rr_sel == tbl_sel_t'(NUM_TABLES - 1)) begin
                rr_sel <= '0;
            end else begin
                rr_sel <= rr_sel + 1'b1;
            end
        end
    end

    // Write command, zero entries while wiping
    always_ff @(posedge clk) begin
        if (srst) begin
            tbl_wr_en <= '0;
            ins_wr_q  <= 1'b0;
        end else if (state == ST_WIPE) begin
            tbl_wr_en <= '1;
            ins_wr_q  <= 1'b0;
        end else begin
            tbl_wr_en <= ins_wr ? ins_mask : '0;
            ins_wr_q  <= ins_wr;
        end
    end

    always_ff @(posedge clk) begin
        for (int t = 0; t < NUM_TABLES; t++) begin
            tbl_wr_addr[t] <= (state == ST_WIPE) ? wipe_addr : idx[t];
        end
        if (state == ST_WIPE) begin
            tbl_wr_entry <= '0;
        end else begin
            tbl_wr_entry <= '{valid: 1'b1, key: key_q, value: value_q};
        end
    end

    // ------------------------------
    // Response combine and credits
    // ------------------------------

    assign fifo_pop = ~|fifo_empty;

    // Highest-numbered hitting table wins
    always_comb begin
        resp_next = '0;
        for (int t = 0; t < NUM_TABLES; t++) begin
            if (fifo_data[t].hit) begin
                resp_next.hit   = 1'b1;
                resp_next.value = fifo_data[t].value;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (srst) begin
            resp_valid    <= 1'b0;
            lookup_credit <= 1'b0;
            insert_credit <= 1'b0;
        end else begin
            resp_valid    <= fifo_pop;
            lookup_credit <= fifo_pop;
            insert_credit <= ins_wr_q;
        end
    end

    always_ff @(posedge clk) begin
        resp <= resp_next;
    end

endmodule : htable_multi_ctrl

// ==== htable_multi_top.f ====
+incdir+.
htable_pkg.sv
htable_hash.sv
htable_mem.sv
htable_resp_fifo.sv
htable_multi_ctrl.sv
htable_multi_top.sv
tb_clk_gen.sv
tb_htable_multi.sv

// ==== htable_multi_top.sv ====
`timescale 1ns/10ps
`include "htable_consts.svh"

module htable_multi_top #(
    parameter htable_pkg::htable_insert_mode_t INSERT_MODE = htable_pkg::INSERT_ROUND_ROBIN
) (
    input  logic                     clk,
    input  logic                     srst,
    input  logic                     clear,
    output logic                     init_done,

    input  logic                     lookup_valid,
    input  htable_pkg::lookup_req_t  lookup_req,
    output logic                     lookup_credit,
    output logic                     resp_valid,
    output htable_pkg::lookup_resp_t resp,

    input  logic                     insert_valid,
    input  htable_pkg::insert_req_t  insert_req,
    output logic                     insert_credit
);
    import htable_pkg::*;

    localparam int NUM_TABLES = `HTABLE_NUM_TABLES;

    key_t                  hash_key;
    logic                  hash_key_valid;
    tbl_addr_t             idx [NUM_TABLES];
    logic                  idx_valid;
    logic                  key_valid_lookup;
    key_t                  tbl_rd_key;
    logic [NUM_TABLES-1:0] tbl_wr_en;
    tbl_addr_t             tbl_wr_addr [NUM_TABLES];
    tbl_entry_t            tbl_wr_entry;
    logic                  fifo_srst;
    logic [NUM_TABLES-1:0] fifo_empty;
    logic                  fifo_pop;
    lookup_resp_t          fifo_data [NUM_TABLES];

    htable_multi_ctrl #(
        .INSERT_MODE ( INSERT_MODE )
    ) i_ctrl (
        .clk              ( clk ),
        .srst             ( srst ),
        .clear            ( clear ),
        .init_done        ( init_done ),
        .lookup_valid     ( lookup_valid ),
        .lookup_req       ( lookup_req ),
        .insert_valid     ( insert_valid ),
        .insert_req       ( insert_req ),
        .hash_key         ( hash_key ),
        .hash_key_valid   ( hash_key_valid ),
        .idx              ( idx ),
        .idx_valid        ( idx_valid ),
        .key_valid_lookup ( key_valid_lookup ),
        .tbl_rd_key       ( tbl_rd_key ),
        .tbl_wr_en        ( tbl_wr_en ),
        .tbl_wr_addr      ( tbl_wr_addr ),
        .tbl_wr_entry     ( tbl_wr_entry ),
        .fifo_srst        ( fifo_srst ),
        .fifo_empty       ( fifo_empty ),
        .fifo_pop         ( fifo_pop ),
        .fifo_data        ( fifo_data ),
        .resp_valid       ( resp_valid ),
        .resp             ( resp ),
        .lookup_credit    ( lookup_credit ),
        .insert_credit    ( insert_credit )
    );

    htable_hash i_hash (
        .clk       ( clk ),
        .srst      ( srst ),
        .key       ( hash_key ),
        .key_valid ( hash_key_valid ),
        .idx       ( idx ),
        .idx_valid ( idx_valid )
    );

    // ------------------------------
    // One table and result FIFO each
    // ------------------------------

    for (genvar g_tbl = 0; g_tbl < NUM_TABLES; g_tbl++) begin : g_tbl_slice
        logic         rd_done;
        logic         rd_hit;
        value_t       rd_value;
        lookup_resp_t rd_resp;

        htable_mem #(
            .ADDR_W ( `HTABLE_ADDR_W )
        ) i_mem (
            .clk      ( clk ),
            .wr_en    ( tbl_wr_en[g_tbl] ),
            .wr_addr  ( tbl_wr_addr[g_tbl] ),
            .wr_entry ( tbl_wr_entry ),
            .rd_en    ( key_valid_lookup ),
            .rd_addr  ( idx[g_tbl] ),
            .rd_key   ( tbl_rd_key ),
            .rd_done  ( rd_done ),
            .rd_hit   ( rd_hit ),
            .rd_value ( rd_value )
        );

        assign rd_resp = '{hit: rd_hit, value: rd_value};

        htable_resp_fifo #(
            .DEPTH ( `HTABLE_LOOKUP_CREDITS )
        ) i_resp_fifo (
            .clk       ( clk ),
            .srst      ( fifo_srst ),
            .push      ( rd_done ),
            .push_data ( rd_resp ),
            .pop       ( fifo_pop ),
            .pop_data  ( fifo_data[g_tbl] ),
            .empty     ( fifo_empty[g_tbl] )
        );
    end : g_tbl_slice

endmodule : htable_multi_top

// ==== htable_pkg.sv ====
`include "htable_consts.svh"

package htable_pkg;

    typedef logic [`HTABLE_KEY_W-1:0]                 key_t;
    typedef logic [`HTABLE_VALUE_W-1:0]               value_t;
    typedef logic [`HTABLE_ADDR_W-1:0]                tbl_addr_t;
    typedef logic [$clog2(`HTABLE_NUM_TABLES)-1:0]    tbl_sel_t;

    typedef enum logic {
        INSERT_ROUND_ROBIN,
        INSERT_BROADCAST
    } htable_insert_mode_t;

    typedef enum logic {
        ST_WIPE,
        ST_RUN
    } htable_ctrl_state_t;

    typedef struct packed {
        key_t   key;
    } lookup_req_t;

    typedef struct packed {
        key_t   key;
        value_t value;
    } insert_req_t;

    typedef struct packed {
        logic   hit;
        value_t value;
    } lookup_resp_t;

    // Stored table entry, 33 bits
    typedef struct packed {
        logic   valid;
        key_t   key;
        value_t value;
    } tbl_entry_t;

endpackage : htable_pkg

// ==== htable_resp_fifo.sv ====
`timescale 1ns/10ps
`include "htable_consts.svh"

module htable_resp_fifo #(
    parameter int DEPTH = `HTABLE_LOOKUP_CREDITS
) (
    input  logic                     clk,
    input  logic                     srst,
    input  logic                     push,
    input  htable_pkg::lookup_resp_t push_data,
    input  logic                     pop,
    output htable_pkg::lookup_resp_t pop_data,
    output logic                     empty
);
    import htable_pkg::*;

    // DEPTH is a power of two, pointers carry one wrap bit
    localparam int IDX_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

    lookup_resp_t   slots [DEPTH];
    logic [IDX_W:0] wr_ptr;
    logic [IDX_W:0] rd_ptr;

    always_ff @(posedge clk) begin
        if (srst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            slots[wr_ptr[IDX_W-1:0]] <= push_data;
        end
    end

    // Head is visible without a pop
    assign pop_data = slots[rd_ptr[IDX_W-1:0]];
    assign empty    = (wr_ptr == rd_ptr);

endmodule : htable_resp_fifo

// ==== tb_clk_gen.sv ====
`timescale 1ns/10ps

module tb_clk_gen #(
    parameter int PERIOD_NS = 8
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
    end

    // Free running, half period per phase
    always begin
        #(PERIOD_NS / 2) clk = ~clk;
    end

endmodule : tb_clk_gen

// ==== tb_htable_multi.sv ====
`timescale 1ns/10ps
`include "htable_consts.svh"

module tb_htable_multi #(
    parameter int MODE_SEL = 0
);
    import htable_pkg::*;

    localparam htable_insert_mode_t INSERT_MODE =
        (MODE_SEL != 0) ? INSERT_BROADCAST : INSERT_ROUND_ROBIN;
    localparam int          NUM_TABLES = `HTABLE_NUM_TABLES;
    localparam int          DEPTH      = 1 << `HTABLE_ADDR_W;
    localparam int          CREDITS    = `HTABLE_LOOKUP_CREDITS;
    localparam int          TIMEOUT    = 500;
    localparam int          KEY_SPAN   = 256;
    localparam int unsigned SEED       = 32'h906f7721;

    // Response registered at edge 3 when the accepting edge is edge 0,
    // which is the fourth falling edge after the request is driven
    localparam int          RESP_STEPS = 4;

    logic         clk;
    logic         srst;
    logic         clear;
    logic         init_done;
    logic         lookup_valid;
    lookup_req_t  lookup_req;
    logic         lookup_credit;
    logic         resp_valid;
    lookup_resp_t resp;
    logic         insert_valid;
    insert_req_t  insert_req;
    logic         insert_credit;

    // Reference model state
    tbl_entry_t   model_tbl [NUM_TABLES][DEPTH];
    int           model_rr;
    lookup_resp_t exp_q [$];
    int           due_q [$];
    int           cyc;
    key_t         used_keys [$];
    int           credits;
    logic         ins_pending;

    tb_clk_gen #(.PERIOD_NS(8)) i_clk_gen (.clk(clk));

    htable_multi_top #(
        .INSERT_MODE ( INSERT_MODE )
    ) DUT (
        .clk           ( clk ),
        .srst          ( srst ),
        .clear         ( clear ),
        .init_done     ( init_done ),
        .lookup_valid  ( lookup_valid ),
        .lookup_req    ( lookup_req ),
        .lookup_credit ( lookup_credit ),
        .resp_valid    ( resp_valid ),
        .resp          ( resp ),
        .insert_valid  ( insert_valid ),
        .insert_req    ( insert_req ),
        .insert_credit ( insert_credit )
    );

    // ------------------------------
    // Failure handling and compares
    // ------------------------------

    task automatic abort_run();
        $display("** FAIL **");
        $fatal(1, "simulation stopped on first error");
    endtask

    task automatic report_failure(input string why);
        $display("%s", why);
        abort_run();
    endtask

    task automatic check_resp(input string name, input lookup_resp_t got,
                              input lookup_resp_t exp);
        if (got !== exp) begin
            $display("FAIL %s got 0x%0h expected 0x%0h", name, got, exp);
            abort_run();
        end
    endtask

    task automatic check_credit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("FAIL %s got 0x%0h expected 0x%0h", name, got, exp);
            abort_run();
        end
    endtask

    // ------------------------------
    // Reference model
    // ------------------------------

    // Rotate left by 5 bits per table, then fold the bytes
    function automatic tbl_addr_t model_index(input key_t k, input int tbl);
        logic [31:0] dbl;
        key_t        rot;
        logic [7:0]  fold;
        dbl  = {k, k} << ((5 * tbl) % 16);
        rot  = dbl[31:16];
        fold = rot[15:8] ^ rot[7:0];
        return fold[`HTABLE_ADDR_W-1:0];
    endfunction

    task automatic model_clear();
        for (int t = 0; t < NUM_TABLES; t++) begin
            for (int a = 0; a < DEPTH; a++) begin
                model_tbl[t][a] = '0;
            end
        end
        model_rr = 0;
    endtask

    task automatic model_insert(input key_t k, input value_t v);
        for (int t = 0; t < NUM_TABLES; t++) begin
            if (INSERT_MODE == INSERT_BROADCAST || t == model_rr) begin
                model_tbl[t][model_index(k, t)] = '{valid: 1'b1, key: k, value: v};
            end
        end
        if (INSERT_MODE == INSERT_ROUND_ROBIN) begin
            model_rr = (model_rr + 1) % NUM_TABLES;
        end
    endtask

    // Later tables override earlier ones on a hit
    function automatic lookup_resp_t model_lookup(input key_t k);
        lookup_resp_t r;
        tbl_entry_t   e;
        r = '0;
        for (int t = 0; t < NUM_TABLES; t++) begin
            e = model_tbl[t][model_index(k, t)];
            if (e.valid && e.key == k) begin
                r.hit   = 1'b1;
                r.value = e.value;
            end
        end
        return r;
    endfunction

    // ------------------------------
    // Cycle step and waits
    // ------------------------------

    // Outputs are sampled on the falling edge, inputs change right after
    task automatic step();
        logic resp_due;
        @(negedge clk);
        cyc++;
        resp_due = (due_q.size() > 0) && (due_q[0] == cyc);
        check_credit("resp_valid", resp_valid, resp_due);
        check_credit("lookup_credit", lookup_credit, resp_due);
        if (resp_due) begin
            void'(due_q.pop_front());
            check_resp("resp", resp, exp_q.pop_front());
        end
        if (lookup_credit === 1'b1) begin
            credits++;
        end
        if (insert_credit === 1'b1) begin
            check_credit("insert_credit", insert_credit, ins_pending);
            ins_pending = 1'b0;
        end
    endtask

    task automatic wait_init_done();
        int n;
        n = 0;
        while (init_done !== 1'b1) begin
            if (n >= TIMEOUT) begin
                report_failure("init_done did not rise within the timeout");
            end
            step();
            n++;
        end
    endtask

    task automatic wait_lookup_credit();
        int n;
        n = 0;
        while (credits == 0) begin
            if (n >= TIMEOUT) begin
                report_failure("no lookup credit came back within the timeout");
            end
            step();
            n++;
        end
    endtask

    task automatic wait_insert_credit();
        int n;
        n = 0;
        while (ins_pending) begin
            if (n >= TIMEOUT) begin
                report_failure("no insert credit came back within the timeout");
            end
            step();
            n++;
        end
    endtask

    task automatic drain();
        int n;
        n = 0;
        while (exp_q.size() > 0 || ins_pending) begin
            if (n >= TIMEOUT) begin
                report_failure("outstanding requests did not finish within the timeout");
            end
            step();
            n++;
        end
    endtask

    // ------------------------------
    // Requests
    // ------------------------------

    task automatic do_lookup(input key_t k);
        wait_lookup_credit();
        lookup_valid   = 1'b1;
        lookup_req.key = k;
        credits--;
        exp_q.push_back(model_lookup(k));
        due_q.push_back(cyc + RESP_STEPS);
        step();
        lookup_valid = 1'b0;
    endtask

    // Waits for its own credit so later lookups see the write
    task automatic do_insert(input key_t k, input value_t v);
        wait_insert_credit();
        insert_valid = 1'b1;
        insert_req   = '{key: k, value: v};
        ins_pending  = 1'b1;
        model_insert(k, v);
        used_keys.push_back(k);
        step();
        insert_valid = 1'b0;
        wait_insert_credit();
    endtask

    task automatic do_clear();
        drain();
        clear = 1'b1;
        step();
        clear = 1'b0;
        if (init_done !== 1'b0) begin
            report_failure("init_done stayed high after clear");
        end
        model_clear();
        wait_init_done();
    endtask

    // Half the lookups reuse inserted keys, the rest may be absent
    function automatic key_t pick_lookup_key();
        if (used_keys.size() > 0 && $urandom_range(0, 1) == 0) begin
            return used_keys[$urandom_range(0, used_keys.size() - 1)];
        end
        return key_t'($urandom_range(0, 2 * KEY_SPAN - 1));
    endfunction

    // ------------------------------
    // Main sequence
    // ------------------------------

    initial begin
        int unsigned seed_ret;
        key_t        k;
        seed_ret     = $urandom(SEED);
        srst         = 1'b1;
        clear        = 1'b0;
        lookup_valid = 1'b0;
        lookup_req   = '0;
        insert_valid = 1'b0;
        insert_req   = '0;
        credits      = CREDITS;
        ins_pending  = 1'b0;
        cyc          = 0;
        model_clear();
        $display("Insert mode select %0d", MODE_SEL);

        repeat (16) @(negedge clk);
        srst = 1'b0;
        wait_init_done();

        // Freshly wiped tables miss everywhere
        for (int i = 0; i < 8; i++) begin
            do_lookup(key_t'($urandom));
        end
        drain();

        // Narrow key range forces index collisions
        // 70 inserts leave the round-robin pointer away from table 0
        for (int round = 0; round < 7; round++) begin
            for (int i = 0; i < 10; i++) begin
                do_insert(key_t'($urandom_range(0, KEY_SPAN - 1)), value_t'($urandom));
            end
            for (int i = 0; i < 20; i++) begin
                do_lookup(pick_lookup_key());
            end
        end
        drain();

        // Everything inserted so far must be gone
        do_clear();
        for (int i = 0; i < used_keys.size(); i++) begin
            do_lookup(used_keys[i]);
        end
        drain();

        // One key inserted repeatedly shows the table order from 0
        k = key_t'($urandom_range(0, KEY_SPAN - 1));
        for (int i = 0; i < 4; i++) begin
            do_insert(k, value_t'(16'h1000 + i));
            do_lookup(k);
        end
        drain();

        $display("** PASS **");
        $finish;
    end

endmodule : tb_htable_multi
